// File: hdl/cout_axil_regs.sv
`timescale 1ns/1ps

module cout_axil_regs (
    input  logic                   sysclk_i,
    input  logic                   rst_n_i,
    input  cout_pkg::axil_wr_req_t wr_req_i,
    output cout_pkg::axil_wr_rsp_t wr_rsp_o,
    input  cout_pkg::axil_rd_req_t rd_req_i,
    output cout_pkg::axil_rd_rsp_t rd_rsp_o,
    output cout_pkg::cout_ctrl_t   ctrl_o,
    input  cout_pkg::cout_flags_t  flags_i,
    input  cout_pkg::cout_word_t   fifo_rdata_i,
    input  logic                   fifo_empty_i,
    output logic                   pop_o
);
    import cout_pkg::*;

    // write channel state
    logic       aw_ready_q;
    logic       b_valid_q;
    logic [1:0] b_resp_q;
    logic       wr_accept;
    logic       wr_hs;
    logic       wr_mapped;
    logic       wr_byte0;

    // read channel state
    logic        ar_ready_q;
    logic        r_valid_q;
    logic [1:0]  r_resp_q;
    logic [31:0] r_data_q;
    logic        rd_accept;
    logic        rd_hs;
    logic        rd_mapped;
    logic [31:0] rd_value;

    // register contents
    cout_ctrl_t ctrl_q;
    logic       ovf_q;
    logic       biterr_q;
    logic       clr_ovf;
    logic       clr_biterr;

    // take a write only with both address and data, one at a time
    assign wr_accept = wr_req_i.awvalid && wr_req_i.wvalid && !aw_ready_q && !b_valid_q;
    assign wr_hs     = aw_ready_q && wr_req_i.awvalid && wr_req_i.wvalid;
    assign wr_mapped = (wr_req_i.awaddr == REG_CTRL) || (wr_req_i.awaddr == REG_STATUS);
    assign wr_byte0  = wr_hs && wr_req_i.wstrb[0];

    // status clears are write-one
    assign clr_ovf    = wr_byte0 && (wr_req_i.awaddr == REG_STATUS) && wr_req_i.wdata[1];
    assign clr_biterr = wr_byte0 && (wr_req_i.awaddr == REG_STATUS) && wr_req_i.wdata[2];

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_ready_q <= 1'b0;
            b_valid_q  <= 1'b0;
        end else begin
            aw_ready_q <= wr_accept;
            if (wr_hs) begin
                b_valid_q <= 1'b1;
            end else if (wr_req_i.bready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (wr_hs) begin
            b_resp_q <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // all control fields live in byte 0
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (wr_byte0 && (wr_req_i.awaddr == REG_CTRL)) begin
            ctrl_q.capture_en <= wr_req_i.wdata[0];
            ctrl_q.check_en   <= wr_req_i.wdata[1];
            ctrl_q.offset     <= wr_req_i.wdata[7:4];
        end
    end

    // a new event in the same clock beats the clear
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ovf_q    <= 1'b0;
            biterr_q <= 1'b0;
        end else begin
            ovf_q    <= flags_i.overflow || (ovf_q && !clr_ovf);
            biterr_q <= flags_i.biterr || (biterr_q && !clr_biterr);
        end
    end

    assign rd_accept = rd_req_i.arvalid && !ar_ready_q && !r_valid_q;
    assign rd_hs     = ar_ready_q && rd_req_i.arvalid;

    // read mux, sampled in the handshake clock
    always_comb begin
        rd_mapped = 1'b1;
        rd_value  = '0;
        case (rd_req_i.araddr)
            REG_CTRL: begin
                rd_value[0]   = ctrl_q.capture_en;
                rd_value[1]   = ctrl_q.check_en;
                rd_value[7:4] = ctrl_q.offset;
            end
            REG_STATUS: begin
                rd_value[0] = !fifo_empty_i;
                rd_value[1] = ovf_q;
                rd_value[2] = biterr_q;
            end
            REG_DATA: begin
                rd_value = fifo_empty_i ? '0 : fifo_rdata_i;
            end
            default: begin
                rd_mapped = 1'b0;
            end
        endcase
    end

    // head is latched into rdata on the same edge that pops it
    assign pop_o = rd_hs && (rd_req_i.araddr == REG_DATA);

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else begin
            ar_ready_q <= rd_accept;
            if (rd_hs) begin
                r_valid_q <= 1'b1;
            end else if (rd_req_i.rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // held until the master takes the response
    always_ff @(posedge sysclk_i) begin
        if (rd_hs) begin
            r_data_q <= rd_value;
            r_resp_q <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign wr_rsp_o.awready = aw_ready_q;
    assign wr_rsp_o.wready  = aw_ready_q;
    assign wr_rsp_o.bresp   = b_resp_q;
    assign wr_rsp_o.bvalid  = b_valid_q;

    assign rd_rsp_o.arready = ar_ready_q;
    assign rd_rsp_o.rdata   = r_data_q;
    assign rd_rsp_o.rresp   = r_resp_q;
    assign rd_rsp_o.rvalid  = r_valid_q;

    assign ctrl_o = ctrl_q;

endmodule

// File: hdl/cout_capture_top.sv
`timescale 1ns/1ps

module cout_capture_top (
    input  logic                   sysclk_i,
    input  logic                   rst_n_i,
    input  logic                   sync_i,
    input  cout_pkg::cout_nibble_t cout_i,
    input  cout_pkg::axil_wr_req_t axil_wr_req_i,
    output cout_pkg::axil_wr_rsp_t axil_wr_rsp_o,
    input  cout_pkg::axil_rd_req_t axil_rd_req_i,
    output cout_pkg::axil_rd_rsp_t axil_rd_rsp_o,
    output logic                   biterr_o
);
    import cout_pkg::*;

    cout_ctrl_t  ctrl;
    cout_flags_t flags;
    cout_word_t  push_word;
    cout_word_t  head_word;
    logic        push;
    logic        pop;
    logic        fifo_full;
    logic        fifo_empty;

    // producer, sync alignment lives inside
    cout_parallelizer u_parallelizer (
        .sysclk_i    (sysclk_i),
        .rst_n_i     (rst_n_i),
        .sync_i      (sync_i),
        .cout_i      (cout_i),
        .ctrl_i      (ctrl),
        .fifo_full_i (fifo_full),
        .push_o      (push),
        .word_o      (push_word),
        .flags_o     (flags)
    );

    cout_word_fifo u_word_fifo (
        .sysclk_i (sysclk_i),
        .rst_n_i  (rst_n_i),
        .push_i   (push),
        .pop_i    (pop),
        .wdata_i  (push_word),
        .rdata_o  (head_word),
        .full_o   (fifo_full),
        .empty_o  (fifo_empty)
    );

    // software side
    cout_axil_regs u_axil_regs (
        .sysclk_i     (sysclk_i),
        .rst_n_i      (rst_n_i),
        .wr_req_i     (axil_wr_req_i),
        .wr_rsp_o     (axil_wr_rsp_o),
        .rd_req_i     (axil_rd_req_i),
        .rd_rsp_o     (axil_rd_rsp_o),
        .ctrl_o       (ctrl),
        .flags_i      (flags),
        .fifo_rdata_i (head_word),
        .fifo_empty_i (fifo_empty),
        .pop_o        (pop)
    );

    assign biterr_o = flags.biterr;

endmodule

// File: hdl/cout_parallelizer.sv
`timescale 1ns/1ps

module cout_parallelizer (
    input  logic                  sysclk_i,
    input  logic                  rst_n_i,
    input  logic                  sync_i,
    input  cout_pkg::cout_nibble_t cout_i,
    input  cout_pkg::cout_ctrl_t  ctrl_i,
    input  logic                  fifo_full_i,
    output logic                  push_o,
    output cout_pkg::cout_word_t  word_o,
    output cout_pkg::cout_flags_t flags_o
);
    import cout_pkg::*;

    logic sync_delayed;
    logic sync_half;
    logic capture_pt;

    // the last eight nibbles, entry 0 is the oldest
    // upper seven fill out the word, entry 0 is the repeat reference
    cout_nibble_t [NIBBLES_PER_WORD-1:0] hist_q;

    cout_word_t word_now;
    logic       nibble_mismatch;

    cout_sync_delay u_sync_delay (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .sync_i         (sync_i),
        .offset_i       (ctrl_i.offset),
        .sync_delayed_o (sync_delayed),
        .sync_half_o    (sync_half)
    );

    assign capture_pt = sync_delayed || sync_half;

    // live nibble on top, then t-1 down to t-7
    assign word_now = {cout_i, hist_q[NIBBLES_PER_WORD-1:1]};

    // stream repeats every eight nibbles
    assign nibble_mismatch = (cout_i != hist_q[0]);

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_q <= '0;
        end else begin
            hist_q <= {cout_i, hist_q[NIBBLES_PER_WORD-1:1]};
        end
    end

    // word register, only meaningful alongside push_o
    always_ff @(posedge sysclk_i) begin
        if (capture_pt) begin
            word_o <= word_now;
        end
    end

    // push or drop the captured word one clock after the capture point
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            push_o           <= 1'b0;
            flags_o.overflow <= 1'b0;
        end else begin
            push_o           <= capture_pt && ctrl_i.capture_en && !fifo_full_i;
            flags_o.overflow <= capture_pt && ctrl_i.capture_en && fifo_full_i;
        end
    end

    // checked on every clock, not just at capture points
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flags_o.biterr <= 1'b0;
        end else begin
            flags_o.biterr <= ctrl_i.check_en && nibble_mismatch;
        end
    end

endmodule

// File: hdl/cout_pkg.sv
package cout_pkg;

    // stream timing
    localparam int SYNC_PERIOD      = 16;
    localparam int SYNC_HALF        = 8;
    localparam int NIBBLES_PER_WORD = 8;

    // word buffer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

    // register byte addresses
    localparam logic [3:0] REG_CTRL   = 4'd0;
    localparam logic [3:0] REG_STATUS = 4'd4;
    localparam logic [3:0] REG_DATA   = 4'd8;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef logic [3:0] cout_nibble_t;

    // newest nibble sits in bits 31:28
    typedef logic [31:0] cout_word_t;

    typedef struct packed {
        logic       capture_en;
        logic       check_en;
        logic [3:0] offset;
    } cout_ctrl_t;

    // one-cycle event pulses
    typedef struct packed {
        logic biterr;
        logic overflow;
    } cout_flags_t;

    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic [3:0] araddr;
        logic       arvalid;
        logic       rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rd_rsp_t;

endpackage

// File: hdl/cout_sync_delay.sv
`timescale 1ns/1ps

module cout_sync_delay (
    input  logic       sysclk_i,
    input  logic       rst_n_i,
    input  logic       sync_i,
    input  logic [3:0] offset_i,
    output logic       sync_delayed_o,
    output logic       sync_half_o
);
    import cout_pkg::*;

    // past sync samples, bit j is sync_i from j+1 clocks ago
    logic [SYNC_PERIOD-2:0] sync_sr;

    // tap j is sync_i delayed by j clocks, tap 0 is the live input
    logic [SYNC_PERIOD-1:0] sync_taps;

    // fixed half-period line behind the delayed sync
    logic [SYNC_HALF-1:0]   half_sr;

    assign sync_taps = {sync_sr, sync_i};

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_sr <= '0;
        end else begin
            sync_sr <= sync_taps[SYNC_PERIOD-2:0];
        end
    end

    // output register adds the one clock on top of the tap
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_delayed_o <= 1'b0;
        end else begin
            sync_delayed_o <= sync_taps[offset_i];
        end
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            half_sr <= '0;
        end else begin
            half_sr <= {half_sr[SYNC_HALF-2:0], sync_delayed_o};
        end
    end

    // SYNC_HALF clocks after the delayed sync
    assign sync_half_o = half_sr[SYNC_HALF-1];

endmodule

// File: hdl/cout_word_fifo.sv
`timescale 1ns/1ps

module cout_word_fifo (
    input  logic                 sysclk_i,
    input  logic                 rst_n_i,
    input  logic                 push_i,
    input  logic                 pop_i,
    input  cout_pkg::cout_word_t wdata_i,
    output cout_pkg::cout_word_t rdata_o,
    output logic                 full_o,
    output logic                 empty_o
);
    import cout_pkg::*;

    cout_word_t mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    logic do_push;
    logic do_pop;

    assign full_o  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty_o = (count == '0);

    // ignore push when full and pop when empty
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // head word, visible without a clock
    assign rdata_o = mem[rd_ptr];

    always_ff @(posedge sysclk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cout capture testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module cout_capture_tb -o cout_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/cout_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation finished without errors"
exit 0

// File: verification/cout_capture_tb.sv
`timescale 1ns/1ps

module cout_capture_tb;
    import cout_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int TEST_CYCLES     = 6000;
    localparam int MARGIN_CYCLES   = 2000;

    logic                 sysclk;
    logic                 rst_n;
    logic                 sync_pulse;
    cout_nibble_t         cout;
    axil_wr_req_t         wr_req;
    axil_wr_rsp_t         wr_rsp;
    axil_rd_req_t         rd_req;
    axil_rd_rsp_t         rd_rsp;
    logic                 biterr;

    integer       seed;
    integer       rnd;
    cout_nibble_t pattern [8];
    int           pat_idx;
    int           sync_cnt;
    int           sync_phase;
    logic         corrupt_req;

    // model state
    cout_nibble_t [7:0] nib_sr;
    logic [14:0]        syn_sr;
    logic [7:0]         del_sr;
    logic               del_cur;
    cout_ctrl_t         ctrl_m;
    int                 cnt_m;
    int                 push_pend;
    logic               ovf_m;
    logic               biterr_m;
    logic               exp_bo;
    int                 bo_pulses;
    cout_word_t         exp_q [$];

    cout_capture_top dut_i (
        .sysclk_i      (sysclk),
        .rst_n_i       (rst_n),
        .sync_i        (sync_pulse),
        .cout_i        (cout),
        .axil_wr_req_i (wr_req),
        .axil_wr_rsp_o (wr_rsp),
        .axil_rd_req_i (rd_req),
        .axil_rd_rsp_o (rd_rsp),
        .biterr_o      (biterr)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("timeout: the test sequence did not finish in time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic fail_run(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(input cout_word_t got, input cout_word_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("%s word got %08h expected %08h", what, got, exp));
        end
    endtask

    // bit 0 not-empty, bit 1 overflow, bit 2 biterr
    task automatic check_status(input logic [2:0] got, input logic [2:0] exp, input logic ne_ok);
        if (got[2:1] !== exp[2:1] || (ne_ok && got[0] !== exp[0])) begin
            fail_run($sformatf("status got %03b expected %03b", got, exp));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("%s response got %0d expected %0d", what, got, exp));
        end
    endtask

    // repeating pattern, one nibble per clock, sync every 16 clocks
    always @(posedge sysclk) begin
        cout       <= corrupt_req ? (pattern[pat_idx] ^ 4'h1) : pattern[pat_idx];
        pat_idx    <= (pat_idx + 1) % NIBBLES_PER_WORD;
        sync_pulse <= (sync_cnt == sync_phase);
        sync_cnt   <= (sync_cnt + 1) % SYNC_PERIOD;
    end

    // cycle model, sampled values belong to the clock just ending
    always @(posedge sysclk) begin
        cout_word_t  w;
        logic        cap;
        logic        full_m;
        logic        pop_m;
        logic [15:0] taps;
        if (!rst_n) begin
            nib_sr    = '0;
            syn_sr    = '0;
            del_sr    = '0;
            del_cur   = 1'b0;
            ctrl_m    = '0;
            cnt_m     = 0;
            push_pend = 0;
            exp_bo    = 1'b0;
        end else begin
            if (biterr !== exp_bo) begin
                fail_run("biterr_o differs from the model");
            end
            exp_bo = ctrl_m.check_en && (cout != nib_sr[7]);
            if (exp_bo) begin
                biterr_m  = 1'b1;
                bo_pulses = bo_pulses + 1;
            end
            cap    = del_cur || del_sr[7];
            full_m = (cnt_m == FIFO_DEPTH);
            w[31:28] = cout;
            for (int i = 0; i < 7; i++) begin
                w[27-4*i -: 4] = nib_sr[i];
            end
            pop_m = rd_rsp.arready && rd_req.arvalid && (rd_req.araddr == REG_DATA)
                    && (cnt_m > 0);
            cnt_m = cnt_m + push_pend - (pop_m ? 1 : 0);
            push_pend = 0;
            if (cap && ctrl_m.capture_en) begin
                if (!full_m) begin
                    exp_q.push_back(w);
                    push_pend = 1;
                end else begin
                    ovf_m = 1'b1;
                end
            end
            taps    = {syn_sr, sync_pulse};
            del_sr  = {del_sr[6:0], del_cur};
            del_cur = taps[ctrl_m.offset];
            syn_sr  = taps[14:0];
            nib_sr  = {nib_sr[6:0], cout};
            if (wr_rsp.awready && wr_req.awvalid && wr_req.wvalid && wr_req.wstrb[0]) begin
                if (wr_req.awaddr == REG_CTRL) begin
                    ctrl_m = {wr_req.wdata[0], wr_req.wdata[1], wr_req.wdata[7:4]};
                end else if (wr_req.awaddr == REG_STATUS) begin
                    if (wr_req.wdata[1]) ovf_m = 1'b0;
                    if (wr_req.wdata[2]) biterr_m = 1'b0;
                end
            end
        end
    end

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge sysclk);
        wr_req.awaddr  <= addr;
        wr_req.wdata   <= data;
        wr_req.wstrb   <= 4'hF;
        wr_req.awvalid <= 1'b1;
        wr_req.wvalid  <= 1'b1;
        wr_req.bready  <= 1'b1;
        @(posedge sysclk);
        while (!wr_rsp.awready) @(posedge sysclk);
        if (wr_rsp.wready !== 1'b1) begin
            fail_run("wready did not rise together with awready");
        end
        wr_req.awvalid <= 1'b0;
        wr_req.wvalid  <= 1'b0;
        @(posedge sysclk);
        while (!wr_rsp.bvalid) @(posedge sysclk);
        resp = wr_rsp.bresp;
    endtask

    // hold > 0 keeps rready low that many clocks after rvalid
    task automatic read_reg(input logic [3:0] addr, input int hold,
                            output cout_word_t data, output logic [1:0] resp);
        cout_word_t first;
        @(posedge sysclk);
        rd_req.araddr  <= addr;
        rd_req.arvalid <= 1'b1;
        rd_req.rready  <= (hold == 0);
        @(posedge sysclk);
        while (!rd_rsp.arready) @(posedge sysclk);
        rd_req.arvalid <= 1'b0;
        // rdata has to survive an address change
        rd_req.araddr  <= ~addr;
        @(posedge sysclk);
        while (!rd_rsp.rvalid) @(posedge sysclk);
        if (hold > 0) begin
            first = rd_rsp.rdata;
            for (int i = 0; i < hold; i++) begin
                @(posedge sysclk);
                if (!rd_rsp.rvalid || rd_rsp.rdata !== first) begin
                    fail_run("read data changed while rready was low");
                end
            end
            rd_req.rready <= 1'b1;
            @(posedge sysclk);
        end
        data = rd_rsp.rdata;
        resp = rd_rsp.rresp;
    endtask

    task automatic expect_data_read();
        cout_word_t got;
        logic [1:0] resp;
        read_reg(REG_DATA, 0, got, resp);
        check_resp(resp, RESP_OKAY, "data read");
        if (exp_q.size() > 0) begin
            check_word(got, exp_q.pop_front(), "captured");
        end else begin
            check_word(got, '0, "empty fifo");
        end
    endtask

    task automatic expect_status(input logic ne_ok);
        cout_word_t got;
        logic [1:0] resp;
        read_reg(REG_STATUS, 0, got, resp);
        check_resp(resp, RESP_OKAY, "status read");
        check_status(got[2:0], {biterr_m, ovf_m, exp_q.size() > 0}, ne_ok);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge sysclk);
    endtask

    initial begin
        cout_word_t got;
        logic [1:0] resp;
        logic [31:0] v;
        sysclk      = 1'b0;
        rst_n       = 1'b0;
        sync_pulse  = 1'b0;
        cout        = '0;
        wr_req      = '0;
        rd_req      = '0;
        corrupt_req = 1'b0;
        ovf_m       = 1'b0;
        biterr_m    = 1'b0;
        bo_pulses   = 0;
        pat_idx     = 0;
        sync_cnt    = 0;
        seed        = 27;
        for (int i = 0; i < NIBBLES_PER_WORD; i++) begin
            rnd = $random(seed);
            pattern[i] = rnd[3:0];
        end
        rnd = $random(seed);
        sync_phase = int'(rnd[3:0]);
        repeat (3) @(posedge sysclk);
        rst_n <= 1'b1;
        idle(12);

        // register readback
        expect_status(1'b1);
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            v = {24'd0, rnd[7:4], 2'b00, rnd[1], 1'b0};
            write_reg(REG_CTRL, v, resp);
            check_resp(resp, RESP_OKAY, "ctrl write");
            read_reg(REG_CTRL, 0, got, resp);
            check_resp(resp, RESP_OKAY, "ctrl read");
            check_word(got, v, "ctrl readback");
        end

        // word alignment at random offsets
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            v = {24'd0, rnd[3:0], 4'd0};
            write_reg(REG_CTRL, v, resp);
            idle(2 * SYNC_PERIOD);
            write_reg(REG_CTRL, v | 32'd1, resp);
            idle(SYNC_PERIOD - 2);
            write_reg(REG_CTRL, v, resp);
            idle(20);
            if (exp_q.size() == 0) begin
                fail_run("no words were captured in the capture window");
            end
            while (exp_q.size() > 0) expect_data_read();
            expect_data_read();
            expect_status(1'b1);
        end

        // overflow
        write_reg(REG_CTRL, 32'h31, resp);
        idle(5 * SYNC_PERIOD);
        write_reg(REG_CTRL, 32'h30, resp);
        idle(20);
        expect_status(1'b1);
        if (!ovf_m) fail_run("overflow was never reached");
        for (int i = 0; i < FIFO_DEPTH; i++) expect_data_read();
        write_reg(REG_STATUS, 32'h2, resp);
        check_resp(resp, RESP_OKAY, "status write");
        expect_status(1'b1);

        // bit errors with checking on, then off
        write_reg(REG_CTRL, 32'h02, resp);
        idle(20);
        write_reg(REG_STATUS, 32'h6, resp);
        bo_pulses = 0;
        corrupt_req <= 1'b1;
        @(posedge sysclk);
        corrupt_req <= 1'b0;
        idle(20);
        if (bo_pulses == 0) fail_run("corrupted nibble raised no bit error");
        expect_status(1'b1);
        write_reg(REG_STATUS, 32'h4, resp);
        expect_status(1'b1);
        write_reg(REG_CTRL, 32'h00, resp);
        corrupt_req <= 1'b1;
        @(posedge sysclk);
        corrupt_req <= 1'b0;
        idle(20);
        expect_status(1'b1);

        // bus corner cases
        expect_data_read();
        read_reg(4'd12, 0, got, resp);
        check_resp(resp, RESP_SLVERR, "unmapped read");
        check_word(got, '0, "unmapped read");
        write_reg(4'd12, 32'hFFFF_FFFF, resp);
        check_resp(resp, RESP_SLVERR, "unmapped write");
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            v = {24'd0, rnd[7:4], 2'b00, rnd[1], rnd[0]};
            write_reg(REG_CTRL, v, resp);
            read_reg(REG_CTRL, 1 + int'(rnd[10:8]), got, resp);
            check_word(got, v, "held ctrl read");
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog.f
hdl/cout_pkg.sv
hdl/cout_sync_delay.sv
hdl/cout_parallelizer.sv
hdl/cout_word_fifo.sv
hdl/cout_axil_regs.sv
hdl/cout_capture_top.sv
verification/cout_capture_tb.sv
